// ==== clk_gen_defines.svh ====
`ifndef CLK_GEN_DEFINES_SVH
`define CLK_GEN_DEFINES_SVH

// Config slave bus widths
`define CLK_GEN_DW 32
`define CLK_GEN_AW 2

// Width of ratio and lock threshold fields
`define CLK_GEN_DIV_W 8

// Lock threshold loaded on reset, in cycles
`define CLK_GEN_LOCK_DEF 16

// Ready must hold this many cycles before a reset release
`define CLK_GEN_RST_HOLD 4

`endif

// ==== clk_gen_pkg.sv ====
`include "clk_gen_defines.svh"

package clk_gen_pkg;

  // Register map of one FLL config slave
  typedef enum logic [`CLK_GEN_AW-1:0] {
    REG_STATUS   = 2'd0,  // Bit 0 lock, bit 1 enable, read only
    REG_DIV      = 2'd1,  // Ratio in bits 7:0
    REG_CTRL     = 2'd2,  // Bit 0 enable
    REG_LOCK_THR = 2'd3   // Lock threshold in bits 7:0
  } fll_reg_e;

  // FLL channel states
  typedef enum logic [1:0] {
    FS_OFF     = 2'd0,
    FS_ACQUIRE = 2'd1,
    FS_LOCKED  = 2'd2
  } fll_state_e;

  // Reset sequencer states, released in order
  typedef enum logic [1:0] {
    RS_HOLD    = 2'd0,  // Both domains in reset
    RS_SOC_UP  = 2'd1,  // SoC released
    RS_ALL_UP  = 2'd2   // Cluster released as well
  } rst_state_e;

endpackage

// ==== fll_channel.sv ====
`timescale 1ns/1ps

`include "clk_gen_defines.svh"

module fll_channel #(
  parameter logic [`CLK_GEN_DIV_W-1:0] DIV_RESET = 8'd2
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   bypass_i,
  input  logic                   req_i,
  input  logic                   wrn_i,
  input  logic [`CLK_GEN_AW-1:0] add_i,
  input  logic [`CLK_GEN_DW-1:0] data_i,
  output logic                   ack_o,
  output logic [`CLK_GEN_DW-1:0] r_data_o,
  output logic                   lock_o,
  output logic                   ready_o,
  output logic                   clk_en_o
);

  localparam int DW    = `CLK_GEN_DW;
  localparam int DIV_W = `CLK_GEN_DIV_W;

  // Config slave
  logic                   ack_q;
  logic [DW-1:0]          r_data_q;
  logic [DW-1:0]          rd_data;
  logic                   accept;
  logic                   cfg_write;
  logic                   en_next;
  clk_gen_pkg::fll_reg_e  reg_sel;

  // Channel registers
  logic [DIV_W-1:0]       div_q;
  logic                   en_q;
  logic [DIV_W-1:0]       thr_q;

  // Lock tracking and divider
  clk_gen_pkg::fll_state_e state_q;
  clk_gen_pkg::fll_state_e state_d;
  logic [DIV_W-1:0]       acq_cnt_q;
  logic [DIV_W:0]         acq_next;
  logic                   acq_done;
  logic [DIV_W-1:0]       div_cnt_q;
  logic                   div_wrap;

  assign reg_sel   = clk_gen_pkg::fll_reg_e'(add_i);
  assign accept    = req_i & ~ack_q;  // Held request is ignored during its ack
  assign cfg_write = accept & ~wrn_i & (reg_sel != clk_gen_pkg::REG_STATUS);

  // Enable as it will be after this cycle's write
  assign en_next = (cfg_write && reg_sel == clk_gen_pkg::REG_CTRL) ? data_i[0] : en_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      div_q <= DIV_RESET;
      en_q  <= 1'b1;
      thr_q <= DIV_W'(`CLK_GEN_LOCK_DEF);
    end else if (accept && !wrn_i) begin
      case (reg_sel)
        clk_gen_pkg::REG_DIV: begin
          // A zero ratio would stall the divider
          if (data_i[DIV_W-1:0] == '0) begin
            div_q <= DIV_W'(1);
          end else begin
            div_q <= data_i[DIV_W-1:0];
          end
        end
        clk_gen_pkg::REG_CTRL:     en_q  <= data_i[0];
        clk_gen_pkg::REG_LOCK_THR: thr_q <= data_i[DIV_W-1:0];
        default: ;  // Status is read only
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    case (reg_sel)
      clk_gen_pkg::REG_STATUS:   rd_data[1:0]       = {en_q, lock_o};
      clk_gen_pkg::REG_DIV:      rd_data[DIV_W-1:0] = div_q;
      clk_gen_pkg::REG_CTRL:     rd_data[0]         = en_q;
      clk_gen_pkg::REG_LOCK_THR: rd_data[DIV_W-1:0] = thr_q;
      default:                   rd_data            = '0;
    endcase
  end

  // Ack one cycle after acceptance, read data alongside
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      r_data_q <= '0;
    end else begin
      ack_q    <= accept;
      r_data_q <= (accept && wrn_i) ? rd_data : '0;
    end
  end

  assign acq_next = {1'b0, acq_cnt_q} + 1'b1;
  assign acq_done = acq_next >= {1'b0, thr_q};

  always_comb begin
    state_d = state_q;
    if (cfg_write) begin
      // Any config change restarts acquisition
      state_d = en_next ? clk_gen_pkg::FS_ACQUIRE : clk_gen_pkg::FS_OFF;
    end else begin
      case (state_q)
        clk_gen_pkg::FS_ACQUIRE: begin
          if (acq_done) begin
            state_d = clk_gen_pkg::FS_LOCKED;
          end
        end
        clk_gen_pkg::FS_LOCKED: state_d = clk_gen_pkg::FS_LOCKED;
        default:                state_d = clk_gen_pkg::FS_OFF;
      endcase
    end
  end

  assign div_wrap = (div_cnt_q == div_q - 1'b1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= clk_gen_pkg::FS_ACQUIRE;  // Enabled by default
      acq_cnt_q <= '0;
      div_cnt_q <= '0;
    end else begin
      state_q <= state_d;

      if (cfg_write || state_q != clk_gen_pkg::FS_ACQUIRE) begin
        acq_cnt_q <= '0;
      end else begin
        acq_cnt_q <= acq_next[DIV_W-1:0];
      end

      // Divider free-runs only while locked
      if (state_q == clk_gen_pkg::FS_LOCKED && !div_wrap) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end else begin
        div_cnt_q <= '0;
      end
    end
  end

  assign ack_o    = ack_q;
  assign r_data_o = r_data_q;
  assign lock_o   = (state_q == clk_gen_pkg::FS_LOCKED);
  assign ready_o  = lock_o | bypass_i;
  assign clk_en_o = bypass_i | (lock_o & (div_cnt_q == '0));  // Pulse on divider wrap

  a_ack_single : assert property (@(posedge clk) disable iff (rst_i) ack_o |=> !ack_o)
    else $error("fll_channel ack held for two cycles");

  // A disabled channel never locks nor strobes
  a_en_quiet : assert property (@(posedge clk) disable iff (rst_i)
    (!en_q && !bypass_i) |-> (!lock_o && !clk_en_o))
    else $error("fll_channel lock or clock enable while disabled");

endmodule

// ==== rst_sequencer.sv ====
`timescale 1ns/1ps

`include "clk_gen_defines.svh"

module rst_sequencer (
  input  logic clk,
  input  logic rst_i,
  input  logic test_mode_i,
  input  logic soc_ready_i,
  input  logic cluster_ready_i,
  output logic rstn_soc_o,
  output logic rstn_cluster_o
);

  localparam int HOLD   = `CLK_GEN_RST_HOLD;
  localparam int HOLD_W = $clog2(HOLD + 1);

  logic soc_rdy_q1;
  logic soc_rdy_q2;
  logic cl_rdy_q1;
  logic cl_rdy_q2;

  clk_gen_pkg::rst_state_e state_q;
  clk_gen_pkg::rst_state_e state_d;
  logic [HOLD_W-1:0]       hold_cnt_q;
  logic                    watch_rdy;
  logic                    hold_done;

  // Ready level the current state waits on
  always_comb begin
    case (state_q)
      clk_gen_pkg::RS_HOLD:   watch_rdy = soc_rdy_q2;
      clk_gen_pkg::RS_SOC_UP: watch_rdy = cl_rdy_q2;
      default:                watch_rdy = 1'b1;
    endcase
  end

  assign hold_done = watch_rdy && (hold_cnt_q == HOLD_W'(HOLD - 1));

  always_comb begin
    state_d = state_q;
    if (hold_done) begin
      case (state_q)
        clk_gen_pkg::RS_HOLD:   state_d = clk_gen_pkg::RS_SOC_UP;
        clk_gen_pkg::RS_SOC_UP: state_d = clk_gen_pkg::RS_ALL_UP;
        default:                state_d = clk_gen_pkg::RS_ALL_UP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      soc_rdy_q1 <= 1'b0;
      soc_rdy_q2 <= 1'b0;
      cl_rdy_q1  <= 1'b0;
      cl_rdy_q2  <= 1'b0;
      state_q    <= clk_gen_pkg::RS_HOLD;
      hold_cnt_q <= '0;
    end else begin
      soc_rdy_q1 <= soc_ready_i;  // Two-flop sync
      soc_rdy_q2 <= soc_rdy_q1;
      cl_rdy_q1  <= cluster_ready_i;
      cl_rdy_q2  <= cl_rdy_q1;
      state_q    <= state_d;

      // Restart the count on any dropout
      if (!watch_rdy || hold_done || state_q == clk_gen_pkg::RS_ALL_UP) begin
        hold_cnt_q <= '0;
      end else begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end
    end
  end

  // Test mode bypasses the sequencing
  assign rstn_soc_o     = test_mode_i ? ~rst_i : (state_q != clk_gen_pkg::RS_HOLD);
  assign rstn_cluster_o = test_mode_i ? ~rst_i : (state_q == clk_gen_pkg::RS_ALL_UP);

  a_rst_order : assert property (@(posedge clk) rstn_cluster_o |-> rstn_soc_o)
    else $error("rst_sequencer cluster released before SoC");

endmodule

// ==== soc_clk_rst_gen.sv ====
`timescale 1ns/1ps

`include "clk_gen_defines.svh"

module soc_clk_rst_gen (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   test_mode_i,
  input  logic                   sel_fll_clk_i,

  input  logic                   soc_fll_req_i,
  input  logic                   soc_fll_wrn_i,
  input  logic [`CLK_GEN_AW-1:0] soc_fll_add_i,
  input  logic [`CLK_GEN_DW-1:0] soc_fll_data_i,
  output logic                   soc_fll_ack_o,
  output logic [`CLK_GEN_DW-1:0] soc_fll_r_data_o,
  output logic                   soc_fll_lock_o,

  input  logic                   cluster_fll_req_i,
  input  logic                   cluster_fll_wrn_i,
  input  logic [`CLK_GEN_AW-1:0] cluster_fll_add_i,
  input  logic [`CLK_GEN_DW-1:0] cluster_fll_data_i,
  output logic                   cluster_fll_ack_o,
  output logic [`CLK_GEN_DW-1:0] cluster_fll_r_data_o,
  output logic                   cluster_fll_lock_o,

  output logic                   clk_soc_en_o,
  output logic                   clk_cluster_en_o,
  output logic                   rstn_soc_sync_o,
  output logic                   rstn_cluster_sync_o
);

  logic soc_ready;  // Lock or reference bypass
  logic cluster_ready;

  fll_channel i_fll_soc (
    .clk      (clk),
    .rst_i    (rst_i),
    .bypass_i (sel_fll_clk_i),
    .req_i    (soc_fll_req_i),
    .wrn_i    (soc_fll_wrn_i),
    .add_i    (soc_fll_add_i),
    .data_i   (soc_fll_data_i),
    .ack_o    (soc_fll_ack_o),
    .r_data_o (soc_fll_r_data_o),
    .lock_o   (soc_fll_lock_o),
    .ready_o  (soc_ready),
    .clk_en_o (clk_soc_en_o)
  );

  fll_channel #(
    .DIV_RESET (8'd4)  // Cluster runs slower out of reset
  ) i_fll_cluster (
    .clk      (clk),
    .rst_i    (rst_i),
    .bypass_i (sel_fll_clk_i),
    .req_i    (cluster_fll_req_i),
    .wrn_i    (cluster_fll_wrn_i),
    .add_i    (cluster_fll_add_i),
    .data_i   (cluster_fll_data_i),
    .ack_o    (cluster_fll_ack_o),
    .r_data_o (cluster_fll_r_data_o),
    .lock_o   (cluster_fll_lock_o),
    .ready_o  (cluster_ready),
    .clk_en_o (clk_cluster_en_o)
  );

  rst_sequencer i_rst_seq (
    .clk             (clk),
    .rst_i           (rst_i),
    .test_mode_i     (test_mode_i),
    .soc_ready_i     (soc_ready),
    .cluster_ready_i (cluster_ready),
    .rstn_soc_o      (rstn_soc_sync_o),
    .rstn_cluster_o  (rstn_cluster_sync_o)
  );

endmodule

// ==== clk_rst_checker.sv ====
`timescale 1ns/1ps

`include "clk_gen_defines.svh"

module clk_rst_checker (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   test_mode_i,
  input  logic                   sel_fll_clk_i,
  input  logic                   soc_req_i,
  input  logic                   soc_wrn_i,
  input  logic                   soc_ack_i,
  input  logic [`CLK_GEN_DW-1:0] soc_r_data_i,
  input  logic                   soc_lock_i,
  input  logic                   cluster_req_i,
  input  logic                   cluster_wrn_i,
  input  logic                   cluster_ack_i,
  input  logic [`CLK_GEN_DW-1:0] cluster_r_data_i,
  input  logic                   cluster_lock_i,
  input  logic                   clk_soc_en_i,
  input  logic                   clk_cluster_en_i,
  input  logic                   rstn_soc_i,
  input  logic                   rstn_cluster_i,
  input  logic [`CLK_GEN_DW-1:0] exp_data_i,
  input  logic                   per_arm_i,
  input  logic                   per_chan_i,
  input  logic [7:0]             per_exp_i,
  input  logic                   lock_wait_i,
  input  logic                   lock_chan_i,
  input  logic [7:0]             lock_lim_i,
  output logic                   lock_fail_o,
  output int                     err_cnt_o
);

  logic [1:0] req;
  logic [1:0] wrn;
  logic [1:0] ack;
  logic [1:0] lock;
  logic [1:0] en;
  logic [1:0] pend_q;     // Accepted last cycle
  logic [1:0] pend_rd_q;
  int         since_q [2];  // Cycles since last ack
  int         ready_run_q;
  logic       rstn_soc_q;
  logic       tm_q;
  logic       arm_q;
  logic       seen_q;
  int         gap_q;
  int         pulses_q;
  logic       fail_q;
  int         err_cnt;

  assign req  = {cluster_req_i, soc_req_i};
  assign wrn  = {cluster_wrn_i, soc_wrn_i};
  assign ack  = {cluster_ack_i, soc_ack_i};
  assign lock = {cluster_lock_i, soc_lock_i};
  assign en   = {clk_cluster_en_i, clk_soc_en_i};

  assign lock_fail_o = fail_q;
  assign err_cnt_o   = err_cnt;

  function automatic string chan_name(input int c);
    return (c != 0) ? "cluster" : "SoC";
  endfunction

  initial err_cnt = 0;

  always @(posedge clk) begin
    for (int c = 0; c < 2; c++) begin
      if (pend_q[c] && !ack[c]) begin
        $display("Missing ack on the %s channel at %0t", chan_name(c), $time);
        err_cnt = err_cnt + 1;
      end
      if (ack[c] && !pend_q[c]) begin
        $display("ERR %0t: %s ack without a pending request", $time, chan_name(c));
        err_cnt = err_cnt + 1;
      end
      if (ack[c] && pend_rd_q[c] &&
          ((c != 0) ? cluster_r_data_i : soc_r_data_i) != exp_data_i) begin
        $display("ERR %0t: %s read got %h, expected %h", $time, chan_name(c),
                 (c != 0) ? cluster_r_data_i : soc_r_data_i, exp_data_i);
        err_cnt = err_cnt + 1;
      end
      pend_q[c]    <= !rst_i && req[c] && !ack[c];
      pend_rd_q[c] <= wrn[c];
      since_q[c]   <= rst_i ? 0 : (ack[c] ? 1 : since_q[c] + 1);
    end

    // Lock deadline after the last ack
    if (!lock_wait_i) begin
      fail_q <= 1'b0;
    end else if (!fail_q && !lock[lock_chan_i] &&
                 since_q[lock_chan_i] >= int'(lock_lim_i) + 2) begin
      $display("Lock missed: %s channel not locked %0d cycles after its last ack",
               chan_name(int'(lock_chan_i)), since_q[lock_chan_i]);
      err_cnt = err_cnt + 1;
      fail_q <= 1'b1;
    end

    if (sel_fll_clk_i && en != 2'b11) begin
      $display("ERR %0t: enables %b not both high in bypass", $time, en);
      err_cnt = err_cnt + 1;
    end
    if (test_mode_i && (rstn_soc_i != !rst_i || rstn_cluster_i != !rst_i)) begin
      $display("ERR %0t: test mode resets do not follow rst_i", $time);
      err_cnt = err_cnt + 1;
    end
    if (rstn_cluster_i && !rstn_soc_i) begin
      $display("ERR %0t: cluster reset released before SoC", $time);
      err_cnt = err_cnt + 1;
    end
    if (rstn_soc_i && !rstn_soc_q && !test_mode_i && !tm_q &&
        ready_run_q < `CLK_GEN_RST_HOLD) begin
      $display("ERR %0t: SoC reset released after only %0d ready cycles", $time,
               ready_run_q);
      err_cnt = err_cnt + 1;
    end
    ready_run_q <= (rst_i || !(soc_lock_i || sel_fll_clk_i)) ? 0 : ready_run_q + 1;
    rstn_soc_q  <= rstn_soc_i;
    tm_q        <= test_mode_i;

    // Strobe spacing on the selected channel
    if (per_arm_i) begin
      if (en[per_chan_i]) begin
        if (per_exp_i == 8'd0) begin
          $display("ERR %0t: %s enable high while expected quiet", $time,
                   chan_name(int'(per_chan_i)));
          err_cnt = err_cnt + 1;
        end else if (seen_q && gap_q != int'(per_exp_i)) begin
          $display("ERR %0t: %s enable gap %0d, expected %0d", $time,
                   chan_name(int'(per_chan_i)), gap_q, per_exp_i);
          err_cnt = err_cnt + 1;
        end
        seen_q   <= 1'b1;
        pulses_q <= pulses_q + 1;
        gap_q    <= 1;
      end else begin
        gap_q <= gap_q + 1;
      end
    end else begin
      if (arm_q && per_exp_i != 8'd0 && pulses_q < 2) begin
        $display("Too few enable pulses seen on the %s channel to measure a period",
                 chan_name(int'(per_chan_i)));
        err_cnt = err_cnt + 1;
      end
      seen_q   <= 1'b0;
      pulses_q <= 0;
      gap_q    <= 0;
    end
    arm_q <= per_arm_i;
  end

endmodule

// ==== tb_soc_clk_rst_gen.sv ====
`timescale 1ns/1ps

`include "clk_gen_defines.svh"

module tb_soc_clk_rst_gen;

  localparam int MAX_CMD = 128;

  logic                   clk;
  logic                   rst_i;
  logic                   test_mode;
  logic                   sel_fll_clk;
  logic                   soc_req;
  logic                   soc_wrn;
  logic [`CLK_GEN_AW-1:0] soc_add;
  logic [`CLK_GEN_DW-1:0] soc_data;
  logic                   soc_ack;
  logic [`CLK_GEN_DW-1:0] soc_r_data;
  logic                   soc_lock;
  logic                   cluster_req;
  logic                   cluster_wrn;
  logic [`CLK_GEN_AW-1:0] cluster_add;
  logic [`CLK_GEN_DW-1:0] cluster_data;
  logic                   cluster_ack;
  logic [`CLK_GEN_DW-1:0] cluster_r_data;
  logic                   cluster_lock;
  logic                   clk_soc_en;
  logic                   clk_cluster_en;
  logic                   rstn_soc;
  logic                   rstn_cluster;

  // Expectations handed to the checker
  logic [`CLK_GEN_DW-1:0] exp_data;
  logic                   per_arm;
  logic                   per_chan;
  logic [7:0]             per_exp;
  logic                   lock_wait;
  logic                   lock_chan;
  logic [7:0]             lock_lim;
  logic                   lock_fail;
  int                     err_cnt;

  logic [7:0]  op_a   [MAX_CMD];
  logic [7:0]  ch_a   [MAX_CMD];
  logic [1:0]  addr_a [MAX_CMD];
  logic [31:0] data_a [MAX_CMD];
  logic [31:0] exp_a  [MAX_CMD];
  int          n_cmd;
  int          bad_lines;
  int          cyc;
  int          cyc_limit;
  int unsigned seed_val;

  soc_clk_rst_gen soc_clk_rst_gen_inst (
    .clk                  (clk),
    .rst_i                (rst_i),
    .test_mode_i          (test_mode),
    .sel_fll_clk_i        (sel_fll_clk),
    .soc_fll_req_i        (soc_req),
    .soc_fll_wrn_i        (soc_wrn),
    .soc_fll_add_i        (soc_add),
    .soc_fll_data_i       (soc_data),
    .soc_fll_ack_o        (soc_ack),
    .soc_fll_r_data_o     (soc_r_data),
    .soc_fll_lock_o       (soc_lock),
    .cluster_fll_req_i    (cluster_req),
    .cluster_fll_wrn_i    (cluster_wrn),
    .cluster_fll_add_i    (cluster_add),
    .cluster_fll_data_i   (cluster_data),
    .cluster_fll_ack_o    (cluster_ack),
    .cluster_fll_r_data_o (cluster_r_data),
    .cluster_fll_lock_o   (cluster_lock),
    .clk_soc_en_o         (clk_soc_en),
    .clk_cluster_en_o     (clk_cluster_en),
    .rstn_soc_sync_o      (rstn_soc),
    .rstn_cluster_sync_o  (rstn_cluster)
  );

  clk_rst_checker i_checker (
    .clk              (clk),
    .rst_i            (rst_i),
    .test_mode_i      (test_mode),
    .sel_fll_clk_i    (sel_fll_clk),
    .soc_req_i        (soc_req),
    .soc_wrn_i        (soc_wrn),
    .soc_ack_i        (soc_ack),
    .soc_r_data_i     (soc_r_data),
    .soc_lock_i       (soc_lock),
    .cluster_req_i    (cluster_req),
    .cluster_wrn_i    (cluster_wrn),
    .cluster_ack_i    (cluster_ack),
    .cluster_r_data_i (cluster_r_data),
    .cluster_lock_i   (cluster_lock),
    .clk_soc_en_i     (clk_soc_en),
    .clk_cluster_en_i (clk_cluster_en),
    .rstn_soc_i       (rstn_soc),
    .rstn_cluster_i   (rstn_cluster),
    .exp_data_i       (exp_data),
    .per_arm_i        (per_arm),
    .per_chan_i       (per_chan),
    .per_exp_i        (per_exp),
    .lock_wait_i      (lock_wait),
    .lock_chan_i      (lock_chan),
    .lock_lim_i       (lock_lim),
    .lock_fail_o      (lock_fail),
    .err_cnt_o        (err_cnt)
  );

  always #50 clk = ~clk;

  // Run limit scales with the command count
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc_limit != 0 && cyc >= cyc_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cyc_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic read_stimulus(input int fd);
    string       line;
    logic [7:0]  op;
    logic [7:0]  ch;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    int          cnt;
    while (!$feof(fd) && n_cmd < MAX_CMD) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%c %c %h %h %h", op, ch, a, d, e) == 5) begin
          op_a[n_cmd]   = op;
          ch_a[n_cmd]   = ch;
          addr_a[n_cmd] = a[1:0];
          data_a[n_cmd] = d;
          exp_a[n_cmd]  = e;
          n_cmd = n_cmd + 1;
        end
      end
    end
  endtask

  // Request held until ack seen
  task automatic xfer(input bit cl, input logic wrn, input logic [1:0] a,
                      input logic [31:0] d);
    if (cl) begin
      cluster_req  <= 1'b1;
      cluster_wrn  <= wrn;
      cluster_add  <= a;
      cluster_data <= d;
    end else begin
      soc_req  <= 1'b1;
      soc_wrn  <= wrn;
      soc_add  <= a;
      soc_data <= d;
    end
    do @(posedge clk); while (!(cl ? cluster_ack : soc_ack));
    soc_req     <= 1'b0;
    cluster_req <= 1'b0;
  endtask

  task automatic wait_lock(input bit cl, input logic [7:0] lim);
    lock_chan <= cl;
    lock_lim  <= lim;
    lock_wait <= 1'b1;
    do @(posedge clk); while (!(cl ? cluster_lock : soc_lock) && !lock_fail);
    lock_wait <= 1'b0;
  endtask

  task automatic measure_period(input bit cl, input logic [7:0] n);
    int window;
    window = 3 * int'(n) + 4;
    per_chan <= cl;
    per_exp  <= n;
    per_arm  <= 1'b1;
    repeat (window) @(posedge clk);
    per_arm <= 1'b0;
    @(posedge clk);  // Checker sees the window close
  endtask

  task automatic pulse_reset(input logic tm);
    test_mode <= tm;
    rst_i     <= 1'b1;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
  endtask

  task automatic run_commands();
    bit cl;
    int gap;
    for (int i = 0; i < n_cmd; i++) begin
      cl = (ch_a[i] == "C");
      case (op_a[i])
        "W": xfer(cl, 1'b0, addr_a[i], data_a[i]);
        "R": begin
          exp_data <= exp_a[i];
          xfer(cl, 1'b1, addr_a[i], '0);
        end
        "L": wait_lock(cl, exp_a[i][7:0]);
        "P": measure_period(cl, exp_a[i][7:0]);
        "B": sel_fll_clk <= data_a[i][0];
        "M": pulse_reset(data_a[i][0]);
        default: begin
          $display("Unknown operation in stimulus line %0d", i);
          bad_lines = bad_lines + 1;
        end
      endcase
      gap = $urandom % 4;  // Idle gap between commands
      repeat (gap) @(posedge clk);
      @(posedge clk);
    end
  endtask

  initial begin
    int fd;
    seed_val = $urandom(7);
    clk          = 1'b0;
    cyc          = 0;
    cyc_limit    = 0;
    n_cmd        = 0;
    bad_lines    = 0;
    rst_i        <= 1'b1;
    test_mode    <= 1'b0;
    sel_fll_clk  <= 1'b0;
    soc_req      <= 1'b0;
    soc_wrn      <= 1'b0;
    soc_add      <= '0;
    soc_data     <= '0;
    cluster_req  <= 1'b0;
    cluster_wrn  <= 1'b0;
    cluster_add  <= '0;
    cluster_data <= '0;
    exp_data     <= '0;
    per_arm      <= 1'b0;
    per_chan     <= 1'b0;
    per_exp      <= '0;
    lock_wait    <= 1'b0;
    lock_chan    <= 1'b0;
    lock_lim     <= '0;
    fd = $fopen("clk_rst_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file clk_rst_stimulus.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      read_stimulus(fd);
      $fclose(fd);
      cyc_limit = 300 * n_cmd + 100;
      repeat (4) @(posedge clk);
      rst_i <= 1'b0;
      @(posedge clk);
      run_commands();
      repeat (4) @(posedge clk);
      $display("Run done: %0d checker errors, %0d bad stimulus lines, %0d commands",
               err_cnt, bad_lines, n_cmd);
      if (err_cnt == 0 && bad_lines == 0 && n_cmd > 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== clk_rst_stimulus.txt ====
# op chan addr data expected, fields in hex
# W write, R read, L lock wait (expected = threshold), P period, B bypass, M test mode + reset
L S 0 00000000 10
L C 0 00000000 10
R S 0 00000000 3
R C 0 00000000 3
P S 0 00000000 2
P C 0 00000000 4
R S 1 00000000 2
R C 1 00000000 4
R S 3 00000000 10
W S 1 00000005 0
R S 0 00000000 2
R S 1 00000000 5
L S 0 00000000 10
P S 0 00000000 5
W S 1 00000000 0
R S 1 00000000 1
L S 0 00000000 10
P S 0 00000000 1
W C 3 00000008 0
R C 0 00000000 2
R C 3 00000000 8
L C 0 00000000 8
P C 0 00000000 4
W C 1 00000003 0
L C 0 00000000 8
P C 0 00000000 3
W C 2 00000000 0
R C 0 00000000 0
R C 2 00000000 0
P C 0 00000000 0
W C 0 00000003 0
R C 0 00000000 0
W C 2 00000001 0
L C 0 00000000 8
R C 0 00000000 3
R C 2 00000000 1
B S 0 00000001 0
W S 2 00000000 0
R S 0 00000000 0
P S 0 00000000 1
P C 0 00000000 1
B S 0 00000000 0
P S 0 00000000 0
M S 0 00000001 0
R S 1 00000000 2
R C 1 00000000 4
L S 0 00000000 10
M S 0 00000000 0
L S 0 00000000 10
L C 0 00000000 10
P C 0 00000000 4
R S 0 00000000 3

// ==== build.f ====
+incdir+.
clk_gen_pkg.sv
fll_channel.sv
rst_sequencer.sv
soc_clk_rst_gen.sv
clk_rst_checker.sv
tb_soc_clk_rst_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench under Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_soc_clk_rst_gen -f build.f

out="$(./obj_dir/Vtb_soc_clk_rst_gen)"
echo "$out"

if grep -qx "TEST PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi
